// File: uart_pkg.sv
package uart_pkg;

    localparam int DATA_BITS      = 8;   // data bits per frame, lsb first
    localparam int OVERSAMPLE     = 16;  // sample ticks per bit
    localparam int BAUD_DIV       = 2;   // clocks per sample tick
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_ADDR_BITS = 3;

    localparam int TICK_BITS     = $clog2(OVERSAMPLE);
    localparam int BIT_CNT_BITS  = $clog2(DATA_BITS);
    localparam int BAUD_CNT_BITS = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    // sized compare values for the counters
    localparam logic [TICK_BITS-1:0]     MID_TICK   = TICK_BITS'(7);  // middle of start bit
    localparam logic [TICK_BITS-1:0]     TICK_LAST  = TICK_BITS'(OVERSAMPLE - 1);
    localparam logic [BIT_CNT_BITS-1:0]  BIT_LAST   = BIT_CNT_BITS'(DATA_BITS - 1);
    localparam logic [BAUD_CNT_BITS-1:0] BAUD_LAST  = BAUD_CNT_BITS'(BAUD_DIV - 1);
    localparam logic [FIFO_ADDR_BITS:0]  FIFO_FULL  = (FIFO_ADDR_BITS + 1)'(FIFO_DEPTH);

    // shared by receiver and transmitter
    typedef enum logic [1:0] {
        idle,
        start,
        data,
        stop
    } serial_state_t;

endpackage

// File: baud_gen.sv
`timescale 1ns/1ps
module baud_gen (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    logic [uart_pkg::BAUD_CNT_BITS-1:0] count;  // clocks since last tick

    // tick is registered, first one BAUD_DIV clocks after reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (count == uart_pkg::BAUD_LAST) begin
            count <= '0;
            tick  <= 1'b1;  // wrap
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

// File: uart_fifo.sv
`timescale 1ns/1ps
module uart_fifo (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wr_en,
    input  logic [uart_pkg::DATA_BITS-1:0] wr_data,
    input  logic                           rd_en,
    output logic [uart_pkg::DATA_BITS-1:0] rd_data,
    output logic                           full,
    output logic                           empty
);

    logic [uart_pkg::DATA_BITS-1:0]      mem [uart_pkg::FIFO_DEPTH];
    logic [uart_pkg::FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [uart_pkg::FIFO_ADDR_BITS-1:0] rd_ptr;
    logic [uart_pkg::FIFO_ADDR_BITS:0]   count;  // entries held
    logic                                do_write;
    logic                                do_read;

    assign do_read  = rd_en && !empty;
    assign do_write = wr_en && (!full || do_read);  // full is fine if one leaves

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_ptr];  // fall through, head always visible
    assign full    = (count == uart_pkg::FIFO_FULL);
    assign empty   = (count == '0);

endmodule

// File: uart_rx.sv
`timescale 1ns/1ps
module uart_rx (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rx,
    input  logic                           tick,
    output logic                           data_ready,
    output logic [uart_pkg::DATA_BITS-1:0] data_out
);

    uart_pkg::serial_state_t state, state_next;
    logic [uart_pkg::TICK_BITS-1:0]    tick_cnt, tick_next;  // ticks within the bit
    logic [uart_pkg::BIT_CNT_BITS-1:0] bit_cnt, bit_next;    // data bits taken so far
    logic [uart_pkg::DATA_BITS-1:0]    data_reg, data_next;  // byte being rebuilt
    logic                              ready_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= uart_pkg::idle;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            data_ready <= 1'b0;
        end else begin
            state      <= state_next;
            tick_cnt   <= tick_next;
            bit_cnt    <= bit_next;
            data_ready <= ready_next;
        end
    end

    always_ff @(posedge clk) begin
        data_reg <= data_next;
    end

    always_comb begin
        state_next = state;
        tick_next  = tick_cnt;
        bit_next   = bit_cnt;
        data_next  = data_reg;
        ready_next = 1'b0;
        case (state)
            uart_pkg::idle: begin
                if (!rx) begin  // falling edge marks start bit
                    state_next = uart_pkg::start;
                    tick_next  = '0;
                end
            end
            uart_pkg::start: begin
                if (tick) begin
                    if (tick_cnt == uart_pkg::MID_TICK) begin
                        // now centred in the bit, sample every 16 ticks from here
                        state_next = uart_pkg::data;
                        tick_next  = '0;
                        bit_next   = '0;
                    end else begin
                        tick_next = tick_cnt + 1'b1;
                    end
                end
            end
            uart_pkg::data: begin
                if (tick) begin
                    if (tick_cnt == uart_pkg::TICK_LAST) begin
                        tick_next = '0;
                        data_next = {rx, data_reg[uart_pkg::DATA_BITS-1:1]};  // lsb first
                        if (bit_cnt == uart_pkg::BIT_LAST) begin
                            state_next = uart_pkg::stop;
                        end else begin
                            bit_next = bit_cnt + 1'b1;
                        end
                    end else begin
                        tick_next = tick_cnt + 1'b1;
                    end
                end
            end
            uart_pkg::stop: begin
                if (tick) begin
                    if (tick_cnt == uart_pkg::TICK_LAST) begin
                        state_next = uart_pkg::idle;
                        ready_next = 1'b1;  // stop bit not checked
                    end else begin
                        tick_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: state_next = uart_pkg::idle;
        endcase
    end

    assign data_out = data_reg;

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps
module uart_tx (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           tick,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    input  logic                           tx_avail,
    output logic                           tx_pop,
    output logic                           tx
);

    uart_pkg::serial_state_t state, state_next;
    logic [uart_pkg::TICK_BITS-1:0]    tick_cnt, tick_next;
    logic [uart_pkg::BIT_CNT_BITS-1:0] bit_cnt, bit_next;      // data bits sent so far
    logic [uart_pkg::DATA_BITS-1:0]    shift_reg, shift_next;  // remaining data bits
    logic                              tx_next;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;  // line idles high
        end else begin
            state    <= state_next;
            tick_cnt <= tick_next;
            bit_cnt  <= bit_next;
            tx       <= tx_next;
        end
    end

    always_ff @(posedge clk) begin
        shift_reg <= shift_next;
    end

    always_comb begin
        state_next = state;
        tick_next  = tick_cnt;
        bit_next   = bit_cnt;
        shift_next = shift_reg;
        tx_next    = tx;
        tx_pop     = 1'b0;
        case (state)
            uart_pkg::idle: begin
                tx_next = 1'b1;
                if (tx_avail) begin
                    tx_pop     = 1'b1;  // take the head of the fifo
                    shift_next = tx_data;
                    state_next = uart_pkg::start;
                    tick_next  = '0;
                    tx_next    = 1'b0;  // start bit
                end
            end
            uart_pkg::start: begin
                if (tick) begin
                    if (tick_cnt == uart_pkg::TICK_LAST) begin
                        state_next = uart_pkg::data;
                        tick_next  = '0;
                        bit_next   = '0;
                        tx_next    = shift_reg[0];
                    end else begin
                        tick_next = tick_cnt + 1'b1;
                    end
                end
            end
            uart_pkg::data: begin
                if (tick) begin
                    if (tick_cnt == uart_pkg::TICK_LAST) begin
                        tick_next = '0;
                        if (bit_cnt == uart_pkg::BIT_LAST) begin
                            state_next = uart_pkg::stop;
                            tx_next    = 1'b1;  // stop bit
                        end else begin
                            bit_next   = bit_cnt + 1'b1;
                            shift_next = shift_reg >> 1;
                            tx_next    = shift_reg[1];
                        end
                    end else begin
                        tick_next = tick_cnt + 1'b1;
                    end
                end
            end
            uart_pkg::stop: begin
                if (tick) begin
                    if (tick_cnt == uart_pkg::TICK_LAST) begin
                        state_next = uart_pkg::idle;
                    end else begin
                        tick_next = tick_cnt + 1'b1;
                    end
                end
            end
            default: state_next = uart_pkg::idle;
        endcase
    end

endmodule

// File: uart_top.sv
`timescale 1ns/1ps
module uart_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rx,
    input  logic                           wr_en,
    input  logic [uart_pkg::DATA_BITS-1:0] wr_data,
    input  logic                           rd_en,
    output logic                           tx,
    output logic                           tx_full,
    output logic [uart_pkg::DATA_BITS-1:0] rd_data,
    output logic                           rx_empty
);

    logic                           tick;     // shared 16x sample rate
    logic [uart_pkg::DATA_BITS-1:0] tx_data;
    logic                           tx_empty;
    logic                           tx_pop;
    logic [uart_pkg::DATA_BITS-1:0] rx_data;
    logic                           rx_ready;
    logic                           rx_full;  // bytes dropped while high

    baud_gen baud_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_fifo tx_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (tx_pop),
        .rd_data (tx_data),
        .full    (tx_full),
        .empty   (tx_empty)
    );

    uart_tx transmitter (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .tx_data  (tx_data),
        .tx_avail (!tx_empty),
        .tx_pop   (tx_pop),
        .tx       (tx)
    );

    uart_rx receiver (
        .clk        (clk),
        .reset      (reset),
        .rx         (rx),
        .tick       (tick),
        .data_ready (rx_ready),
        .data_out   (rx_data)
    );

    uart_fifo rx_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (rx_ready),
        .wr_data (rx_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (rx_full),
        .empty   (rx_empty)
    );

endmodule

// File: uart_checker.sv
`timescale 1ns/1ps
module uart_checker (
    input logic clk,
    input logic reset,
    input logic tick,
    input logic rx_ready,
    input logic rx_full,
    input logic rx_empty,
    input logic tx,
    input logic tx_idle,
    input logic tx_pop,
    input logic tx_empty
);

    int tick_fails  = 0;
    int store_fails = 0;
    int idle_fails  = 0;
    int pop_fails   = 0;
    int failures;

    assign failures = tick_fails + store_fails + idle_fails + pop_fails;

    tick_single: assert property (@(posedge clk) disable iff (reset) tick |=> !tick)
        else begin
            $error("tick high on two clocks in a row");
            tick_fails++;
        end

    // a received byte lands in the fifo one clock after data_ready
    rx_store: assert property (@(posedge clk) disable iff (reset)
                               rx_ready && !rx_full |=> !rx_empty)
        else begin
            $error("received byte not stored in the receive FIFO");
            store_fails++;
        end

    idle_line: assert property (@(posedge clk) disable iff (reset) tx_idle |-> tx)
        else begin
            $error("tx low while the transmitter is idle");
            idle_fails++;
        end

    pop_guard: assert property (@(posedge clk) disable iff (reset) !(tx_pop && tx_empty))
        else begin
            $error("tx_pop while the transmit FIFO is empty");
            pop_fails++;
        end

endmodule

bind uart_top uart_checker checks (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .rx_ready (rx_ready),
    .rx_full  (rx_full),
    .rx_empty (rx_empty),
    .tx       (tx),
    .tx_idle  (transmitter.state == uart_pkg::idle),
    .tx_pop   (tx_pop),
    .tx_empty (tx_empty)
);

// File: tb_uart.sv
`timescale 1ns/1ps
module tb_uart;

    localparam int BIT_CLKS       = uart_pkg::OVERSAMPLE * uart_pkg::BAUD_DIV;
    localparam int FRAME_BITS     = uart_pkg::DATA_BITS + 2;
    localparam int FRAME_CLKS     = FRAME_BITS * BIT_CLKS;
    localparam int TIMEOUT_CYCLES = 2 * 40 * FRAME_CLKS;

    logic                           clk;
    logic                           reset;
    logic                           line;      // serial driver output
    logic                           loop_sel;  // 1 feeds tx back into rx
    logic                           rx;
    logic                           wr_en;
    logic [uart_pkg::DATA_BITS-1:0] wr_data;
    logic                           rd_en;
    logic                           tx;
    logic                           tx_full;
    logic [uart_pkg::DATA_BITS-1:0] rd_data;
    logic                           rx_empty;

    logic [uart_pkg::DATA_BITS-1:0] expected[$];  // receive side model
    logic [uart_pkg::DATA_BITS-1:0] exp_byte;
    logic [31:0]                    seed = 32'd50;
    int                             errors = 0;
    int                             popped = 0;
    int                             cycles = 0;

    assign rx = loop_sel ? tx : line;

    uart_top dut (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .tx       (tx),
        .tx_full  (tx_full),
        .rd_data  (rd_data),
        .rx_empty (rx_empty)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // start bit in bit 0, stop bit on top
    function automatic logic [FRAME_BITS-1:0] frame_of(input logic [uart_pkg::DATA_BITS-1:0] b);
        return {1'b1, b, 1'b0};
    endfunction

    task automatic next_byte(output logic [uart_pkg::DATA_BITS-1:0] b);
        seed = lcg_next(seed);
        b    = seed[23:16];
    endtask

    // while the host reads, the receive fifo drains far faster than bytes arrive
    task automatic rx_model_push(input logic [uart_pkg::DATA_BITS-1:0] b);
        if (rd_en || expected.size() < uart_pkg::FIFO_DEPTH) begin
            expected.push_back(b);
        end
    endtask

    task automatic send_serial(input logic [uart_pkg::DATA_BITS-1:0] b);
        logic [FRAME_BITS-1:0] f;
        f = frame_of(b);
        rx_model_push(b);
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(posedge clk);
            #10;
            line = f[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic host_write(input logic [uart_pkg::DATA_BITS-1:0] b, input logic wait_room,
                              output logic accepted);
        @(posedge clk);
        #10;
        while (wait_room && tx_full) begin
            wr_en = 1'b0;
            @(posedge clk);
            #10;
        end
        accepted = !tx_full;  // full flag holds until the write edge
        wr_en    = 1'b1;
        wr_data  = b;
        if (accepted) begin
            rx_model_push(b);
        end
    endtask

    task automatic host_idle();
        @(posedge clk);
        #10;
        wr_en = 1'b0;
    endtask

    task automatic wait_drained();
        while (expected.size() != 0) @(posedge clk);
        repeat (BIT_CLKS) @(posedge clk);  // transmitter finishes its stop bit
        #10;
    endtask

    task automatic check_bit(input string name, input logic actual, input logic exp);
        assert (actual === exp) else begin
            $display("FAIL time=%0t %s expected=%0b actual=%0b", $time, name, exp, actual);
            errors++;
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d testbench, %0d checker", errors, dut.checks.failures);
    endtask

    // pops happen at the next rising edge, rd_data is stable here
    always @(negedge clk) begin
        if (!reset && rd_en && !rx_empty) begin
            popped++;
            assert (expected.size() != 0) else begin
                $display("time %0t: byte %02h read from rd_data with none expected",
                         $time, rd_data);
                errors++;
            end
            if (expected.size() != 0) begin
                exp_byte = expected.pop_front();
                assert (rd_data === exp_byte) else begin
                    $display("FAIL time=%0t rd_data expected=%02h actual=%02h",
                             $time, exp_byte, rd_data);
                    errors++;
                end
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        report_counts();
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [uart_pkg::DATA_BITS-1:0] b;
        logic                           accepted;
        int                             n_accepted;
        reset    = 1'b1;
        line     = 1'b1;
        loop_sel = 1'b0;
        wr_en    = 1'b0;
        wr_data  = '0;
        rd_en    = 1'b0;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        @(negedge clk);
        check_bit("tx", tx, 1'b1);
        check_bit("rx_empty", rx_empty, 1'b1);
        check_bit("tx_full", tx_full, 1'b0);

        rd_en = 1'b1;  // bytes from the serial driver
        for (int i = 0; i < 10; i++) begin
            next_byte(b);
            send_serial(b);
        end
        wait_drained();

        loop_sel = 1'b1;
        for (int i = 0; i < 10; i++) begin
            next_byte(b);
            host_write(b, 1'b1, accepted);
        end
        host_idle();
        wait_drained();

        n_accepted = 0;  // writes on back to back clocks
        for (int i = 0; i < 12; i++) begin
            next_byte(b);
            host_write(b, 1'b0, accepted);
            if (accepted) begin
                n_accepted++;
            end
        end
        host_idle();
        assert (n_accepted >= uart_pkg::FIFO_DEPTH) else begin
            $display("only %0d of 12 writes were accepted by the transmit FIFO", n_accepted);
            errors++;
        end
        wait_drained();

        loop_sel = 1'b0;
        rd_en    = 1'b0;  // let the receive fifo overflow
        for (int i = 0; i < uart_pkg::FIFO_DEPTH + 2; i++) begin
            next_byte(b);
            send_serial(b);
        end
        @(posedge clk);
        #10;
        popped = 0;
        rd_en  = 1'b1;
        wait_drained();
        check_bit("rx_empty", rx_empty, 1'b1);
        assert (popped == uart_pkg::FIFO_DEPTH) else begin
            $display("FAIL time=%0t popped_bytes expected=%0d actual=%0d",
                     $time, uart_pkg::FIFO_DEPTH, popped);
            errors++;
        end

        report_counts();
        if (errors == 0 && dut.checks.failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: uart_top.f
uart_pkg.sv
baud_gen.sv
uart_fifo.sv
uart_rx.sv
uart_tx.sv
uart_top.sv
uart_checker.sv
tb_uart.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_uart
FILELIST  = uart_top.f
BUILD_DIR = obj_dir
SIM       = $(BUILD_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
